// File: hw/fetch_pkg.sv
// Fetch front end shared types, address increments and the default start address
package fetch_pkg;

    // ======================================================================
    // Addresses and fetched words
    // ======================================================================

    // Byte address where bit 1 picks the halfword and bit 0 stays zero
    typedef logic [31:0] addr_t;

    localparam int unsigned WORD_BYTES = 4;
    localparam int unsigned HALF_BYTES = 2;

    // Start address used when the top level is left at its defaults
    localparam addr_t RESET_PC_DEFAULT = 32'h0000_0080;

    typedef struct packed {
        logic [15:0] upper;
        logic [15:0] lower;
    } half_pair_t;

    // One memory word seen either as a whole instruction or as two halfwords
    typedef union packed {
        logic [31:0] full;
        half_pair_t  halves;
    } fetch_word_u;

    // ======================================================================
    // Aligner to assembler select and the channel payloads
    // ======================================================================

    // SEL_CROSS joins the head lower half above the saved upper half
    typedef enum logic [1:0] {
        SEL_FULL,
        SEL_LOW_HALF,
        SEL_UPPER_HALF,
        SEL_CROSS
    } align_sel_e;

    typedef struct packed {
        addr_t       pc;
        logic [31:0] bits;
        logic        compressed;
    } instr_t;

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

endpackage

// File: hw/pc_gen.sv
// Fetch address counter with request handshake, buffer credits and stale-response discard
`timescale 1ns/1ns

module pc_gen #(
    parameter int unsigned      BUF_DEPTH = 4,
    parameter fetch_pkg::addr_t RESET_PC  = fetch_pkg::RESET_PC_DEFAULT
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  redirect_i,
    input  fetch_pkg::addr_t      redirect_pc_i,
    output logic                  req_valid_o,
    output fetch_pkg::fetch_req_t req_o,
    input  logic                  req_ready_i,
    input  logic                  rsp_valid_i,
    output logic                  buf_wr_o,
    input  logic                  pop_i
);

    // All counters range from zero up to BUF_DEPTH inclusive
    localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

    fetch_pkg::addr_t next_addr_q;
    logic             req_valid_q;
    logic [CNT_W-1:0] inflight_q;
    logic [CNT_W-1:0] inflight_d;
    logic [CNT_W-1:0] used_q;
    logic [CNT_W-1:0] used_d;
    logic [CNT_W-1:0] discard_q;
    logic [CNT_W-1:0] discard_d;
    logic             req_fire;
    logic             rsp_drop;

    assign req_fire = req_valid_q && req_ready_i;

    // A response is dropped while older redirects still owe stale words
    assign rsp_drop = rsp_valid_i && (discard_q != '0);

    // A response landing on the redirect cycle is from the old path as well
    assign buf_wr_o = rsp_valid_i && (discard_q == '0) && !redirect_i;

    assign req_valid_o = req_valid_q;
    assign req_o.addr  = next_addr_q;

    // ======================================================================
    // Credit accounting
    // ======================================================================

    // used counts words in flight plus words sitting in the buffer
    always_comb begin
        inflight_d = inflight_q + CNT_W'(req_fire) - CNT_W'(rsp_valid_i);
        if (redirect_i) begin
            // The buffer is flushed, so only the owed responses hold credits
            discard_d = inflight_d;
            used_d    = inflight_d;
        end else begin
            discard_d = discard_q - CNT_W'(rsp_drop);
            used_d    = used_q + CNT_W'(req_fire) - CNT_W'(pop_i) - CNT_W'(rsp_drop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inflight_q  <= '0;
            used_q      <= '0;
            discard_q   <= '0;
            req_valid_q <= 1'b0;
        end else begin
            inflight_q <= inflight_d;
            used_q     <= used_d;
            discard_q  <= discard_d;
            // Valid never drops while stalled since used cannot grow without a fire
            req_valid_q <= (used_d < CNT_W'(BUF_DEPTH));
        end
    end

    // ======================================================================
    // Request address
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            next_addr_q <= {RESET_PC[31:2], 2'b00};
        end else if (redirect_i) begin
            next_addr_q <= {redirect_pc_i[31:2], 2'b00};
        end else if (req_fire) begin
            next_addr_q <= next_addr_q + fetch_pkg::WORD_BYTES;
        end
    end

endmodule

// File: hw/fetch_buffer.sv
// FIFO of fetched instruction words between the memory responses and the aligner
`timescale 1ns/1ns

module fetch_buffer #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   wr_i,
    input  fetch_pkg::fetch_word_u wr_word_i,
    input  logic                   pop_i,
    output fetch_pkg::fetch_word_u head_o,
    output logic                   empty_o
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
    localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

    fetch_pkg::fetch_word_u mem_q [BUF_DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [CNT_W-1:0]       count_q;
    logic                   do_wr;
    logic                   do_pop;

    // Pointers wrap explicitly so that depths other than powers of two work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Overflow cannot happen because the request side works on credits
    assign do_wr  = wr_i && !flush_i;
    assign do_pop = pop_i && !flush_i && !empty_o;

    assign head_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_q[wr_ptr_q] <= wr_word_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(do_wr) - CNT_W'(do_pop);
        end
    end

endmodule

// File: hw/align_ctrl.sv
// Aligner FSM that walks the halfwords of the buffer head and steers emits, pops and saves
`timescale 1ns/1ns

module align_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   redirect_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    input  fetch_pkg::fetch_word_u head_i,
    input  logic                   empty_i,
    output logic                   pop_o,
    output fetch_pkg::align_sel_e  sel_o,
    output logic                   save_upper_o,
    output logic                   emit_o,
    output logic                   instr_valid_o,
    input  logic                   instr_ready_i
);

    // ALIGNED starts at the lower half, UPPER at the upper half and CROSS
    // completes a 32-bit instruction whose first half is already saved
    typedef enum logic [1:0] {
        ALIGNED,
        UPPER,
        CROSS
    } align_state_e;

    align_state_e state_q;
    align_state_e state_d;
    logic         lower_compressed;
    logic         upper_compressed;

    // RVC encodings never have both low bits set
    assign lower_compressed = (head_i.halves.lower[1:0] != 2'b11);
    assign upper_compressed = (head_i.halves.upper[1:0] != 2'b11);

    assign emit_o = instr_valid_o && instr_ready_i;

    always_comb begin
        state_d       = state_q;
        instr_valid_o = 1'b0;
        pop_o         = 1'b0;
        save_upper_o  = 1'b0;
        sel_o         = fetch_pkg::SEL_FULL;
        // The head belongs to the old path on a redirect cycle
        if (!redirect_i && !empty_i) begin
            case (state_q)
                ALIGNED: begin
                    instr_valid_o = 1'b1;
                    if (lower_compressed) begin
                        sel_o = fetch_pkg::SEL_LOW_HALF;
                        if (instr_ready_i) begin
                            state_d = UPPER;
                        end
                    end else begin
                        pop_o = instr_ready_i;
                    end
                end
                UPPER: begin
                    sel_o = fetch_pkg::SEL_UPPER_HALF;
                    if (upper_compressed) begin
                        instr_valid_o = 1'b1;
                        if (instr_ready_i) begin
                            pop_o   = 1'b1;
                            state_d = ALIGNED;
                        end
                    end else begin
                        // Nothing goes out yet, the other half is in the next word
                        save_upper_o = 1'b1;
                        pop_o        = 1'b1;
                        state_d      = CROSS;
                    end
                end
                CROSS: begin
                    instr_valid_o = 1'b1;
                    sel_o         = fetch_pkg::SEL_CROSS;
                    if (instr_ready_i) begin
                        state_d = UPPER;
                    end
                end
                default: begin
                    state_d = ALIGNED;
                end
            endcase
        end
    end

    // The reset address is word aligned, so the walk starts in ALIGNED
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ALIGNED;
        end else if (redirect_i) begin
            state_q <= redirect_pc_i[1] ? UPPER : ALIGNED;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: hw/instr_assembler.sv
// Instruction datapath holding the saved upper half and the running address
`timescale 1ns/1ns

module instr_assembler #(
    parameter fetch_pkg::addr_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   redirect_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    input  fetch_pkg::fetch_word_u head_i,
    input  fetch_pkg::align_sel_e  sel_i,
    input  logic                   save_upper_i,
    input  logic                   emit_i,
    output fetch_pkg::instr_t      instr_o
);

    logic [15:0]      saved_upper_q;
    fetch_pkg::addr_t pc_q;
    logic             wide_sel;

    // Full words and joined halves are both 32-bit instructions
    assign wide_sel = (sel_i == fetch_pkg::SEL_FULL) || (sel_i == fetch_pkg::SEL_CROSS);

    always_ff @(posedge clk_i) begin
        if (save_upper_i) begin
            saved_upper_q <= head_i.halves.upper;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= {redirect_pc_i[31:1], 1'b0};
        end else if (emit_i) begin
            pc_q <= pc_q + (wide_sel ? fetch_pkg::WORD_BYTES : fetch_pkg::HALF_BYTES);
        end
    end

    // Compressed instructions leave in their 16-bit form, zero extended
    always_comb begin
        instr_o.pc = pc_q;
        case (sel_i)
            fetch_pkg::SEL_LOW_HALF: begin
                instr_o.bits       = {16'h0000, head_i.halves.lower};
                instr_o.compressed = 1'b1;
            end
            fetch_pkg::SEL_UPPER_HALF: begin
                instr_o.bits       = {16'h0000, head_i.halves.upper};
                instr_o.compressed = 1'b1;
            end
            fetch_pkg::SEL_CROSS: begin
                instr_o.bits       = {head_i.halves.lower, saved_upper_q};
                instr_o.compressed = 1'b0;
            end
            default: begin
                instr_o.bits       = head_i.full;
                instr_o.compressed = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/fetch_front.sv
// Fetch front end top level joining address generation, buffer, aligner and assembler
`timescale 1ns/1ns

module fetch_front #(
    parameter int unsigned      BUF_DEPTH = 4,
    parameter fetch_pkg::addr_t RESET_PC  = fetch_pkg::RESET_PC_DEFAULT
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   redirect_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    output logic                   req_valid_o,
    output fetch_pkg::fetch_req_t  req_o,
    input  logic                   req_ready_i,
    input  logic                   rsp_valid_i,
    input  fetch_pkg::fetch_word_u rsp_word_i,
    output logic                   instr_valid_o,
    output fetch_pkg::instr_t      instr_o,
    input  logic                   instr_ready_i
);

    logic                   buf_wr;
    logic                   buf_empty;
    logic                   pop;
    logic                   save_upper;
    logic                   emit;
    fetch_pkg::fetch_word_u head_word;
    fetch_pkg::align_sel_e  sel;

    // ======================================================================
    // Request side
    // ======================================================================

    pc_gen #(
        .BUF_DEPTH(BUF_DEPTH),
        .RESET_PC (RESET_PC)
    ) pc_gen_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .req_valid_o  (req_valid_o),
        .req_o        (req_o),
        .req_ready_i  (req_ready_i),
        .rsp_valid_i  (rsp_valid_i),
        .buf_wr_o     (buf_wr),
        .pop_i        (pop)
    );

    // A redirect empties the buffer at the same edge
    fetch_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) fetch_buffer_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (redirect_i),
        .wr_i     (buf_wr),
        .wr_word_i(rsp_word_i),
        .pop_i    (pop),
        .head_o   (head_word),
        .empty_o  (buf_empty)
    );

    // ======================================================================
    // Instruction side
    // ======================================================================

    align_ctrl align_ctrl_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .head_i       (head_word),
        .empty_i      (buf_empty),
        .pop_o        (pop),
        .sel_o        (sel),
        .save_upper_o (save_upper),
        .emit_o       (emit),
        .instr_valid_o(instr_valid_o),
        .instr_ready_i(instr_ready_i)
    );

    instr_assembler #(
        .RESET_PC(RESET_PC)
    ) instr_assembler_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .head_i       (head_word),
        .sel_i        (sel),
        .save_upper_i (save_upper),
        .emit_i       (emit),
        .instr_o      (instr_o)
    );

endmodule

// File: tests/fetch_front_chk.sv
// Bound assertions on request and instruction handshake stability and address alignment
`timescale 1ns/1ns

module fetch_front_chk (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  redirect_i,
    input logic                  req_valid_i,
    input fetch_pkg::fetch_req_t req_i,
    input logic                  req_ready_i,
    input logic                  instr_valid_i,
    input fetch_pkg::instr_t     instr_i,
    input logic                  instr_ready_i
);

    int unsigned fail_count = 0;

    // A redirect during a stall moves the request to the new path
    req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && !req_ready_i && !redirect_i |=> req_valid_i && $stable(req_i))
    else begin
        $error("Request changed or dropped while stalled");
        fail_count++;
    end

    // The aligner withdraws its output in the cycle of a redirect
    instr_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i && !instr_ready_i |=> redirect_i || (instr_valid_i && $stable(instr_i)))
    else begin
        $error("Instruction changed or dropped while stalled");
        fail_count++;
    end

    pc_align_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i |-> !instr_i.pc[0])
    else begin
        $error("Instruction address is not halfword aligned");
        fail_count++;
    end

endmodule

// File: tests/fetch_front_mon.sv
// Instruction stream checker that follows the memory image by the RVC length rule
`timescale 1ns/1ns

module fetch_front_mon (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [255:0][15:0] image_i,
    input  logic               load_i,
    input  fetch_pkg::addr_t   start_pc_i,
    input  logic               instr_valid_i,
    input  fetch_pkg::instr_t  instr_i,
    input  logic               instr_ready_i,
    output int unsigned        count_o,
    output int unsigned        errors_o
);

    fetch_pkg::addr_t exp_pc;

    // Low bits other than 2'b11 mark a 16-bit instruction
    function automatic fetch_pkg::instr_t expected_at(input fetch_pkg::addr_t pc);
        fetch_pkg::instr_t exp;
        logic [15:0]       first;
        first  = image_i[pc[8:1]];
        exp.pc = pc;
        if (first[1:0] != 2'b11) begin
            exp.bits       = {16'h0000, first};
            exp.compressed = 1'b1;
        end else begin
            exp.bits       = {image_i[8'(pc[8:1] + 8'd1)], first};
            exp.compressed = 1'b0;
        end
        return exp;
    endfunction

    always @(posedge clk_i) begin
        fetch_pkg::instr_t exp;
        int unsigned       bad;
        exp = expected_at(exp_pc);
        bad = 0;
        if (!rst_n_i) begin
            count_o  <= 0;
            errors_o <= 0;
        end else if (instr_valid_i && instr_ready_i) begin
            if (instr_i.pc !== exp.pc) begin
                $display("Fail instr_o.pc: got %h, expected %h", instr_i.pc, exp.pc);
                bad = bad + 1;
            end
            if (instr_i.bits !== exp.bits) begin
                $display("Fail instr_o.bits: got %h, expected %h at pc %h",
                         instr_i.bits, exp.bits, exp.pc);
                bad = bad + 1;
            end
            if (instr_i.compressed !== exp.compressed) begin
                $display("Fail instr_o.compressed: got %h, expected %h at pc %h",
                         instr_i.compressed, exp.compressed, exp.pc);
                bad = bad + 1;
            end
            count_o  <= count_o + 1;
            errors_o <= errors_o + bad;
        end
        if (load_i) begin
            exp_pc <= start_pc_i;
        end else if (rst_n_i && instr_valid_i && instr_ready_i) begin
            exp_pc <= exp.pc + (exp.compressed ? 32'd2 : 32'd4);
        end
    end

endmodule

// File: tests/fetch_front_tb.sv
// Fetch front end testbench with memory model, stimulus table and final report
`timescale 1ns/1ns

module fetch_front_tb;

    localparam int unsigned      BUF_DEPTH  = 4;
    localparam fetch_pkg::addr_t RESET_PC   = fetch_pkg::RESET_PC_DEFAULT;
    localparam int unsigned      NUM_ROWS   = 5;
    localparam int unsigned      WAIT_LIMIT = 2000;
    // One bit per pattern entry, set for a 32-bit instruction, entry 0 in bit 0
    localparam logic [15:0]      PATTERN    = 16'h468F;

    typedef struct packed {
        logic             redirect;
        logic             rand_ready;
        fetch_pkg::addr_t target;
        logic [7:0]       count;
    } stim_row_t;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   redirect;
    fetch_pkg::addr_t       redirect_pc;
    logic                   req_valid;
    fetch_pkg::fetch_req_t  req;
    logic                   req_ready;
    logic                   rsp_valid;
    fetch_pkg::fetch_word_u rsp_word;
    logic                   instr_valid;
    fetch_pkg::instr_t      instr;
    logic                   instr_ready;
    logic [255:0][15:0]     image;
    stim_row_t              stim_table [NUM_ROWS];
    logic                   rand_mode;
    logic                   mon_load;
    fetch_pkg::addr_t       mon_start;
    int unsigned            mon_count;
    int unsigned            mon_errors;
    int unsigned            sva_errors;
    int unsigned            timeouts;
    logic [31:0]            lcg_state;
    int unsigned            cycle;
    int unsigned            last_due;
    fetch_pkg::addr_t       pend_addr [$];
    int unsigned            pend_due [$];

    fetch_front #(
        .BUF_DEPTH(BUF_DEPTH),
        .RESET_PC (RESET_PC)
    ) fetch_front_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .req_valid_o  (req_valid),
        .req_o        (req),
        .req_ready_i  (req_ready),
        .rsp_valid_i  (rsp_valid),
        .rsp_word_i   (rsp_word),
        .instr_valid_o(instr_valid),
        .instr_o      (instr),
        .instr_ready_i(instr_ready)
    );

    fetch_front_mon fetch_front_mon_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .image_i      (image),
        .load_i       (mon_load),
        .start_pc_i   (mon_start),
        .instr_valid_i(instr_valid),
        .instr_i      (instr),
        .instr_ready_i(instr_ready),
        .count_o      (mon_count),
        .errors_o     (mon_errors)
    );

    bind fetch_front fetch_front_chk fetch_front_chk_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .req_valid_i  (req_valid_o),
        .req_i        (req_o),
        .req_ready_i  (req_ready_i),
        .instr_valid_i(instr_valid_o),
        .instr_i      (instr_o),
        .instr_ready_i(instr_ready_i)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Every halfword carries its own index so a misplaced word shows up in the compare
    task automatic build_image();
        int unsigned pos;
        int unsigned k;
        logic [7:0]  idx;
        pos = 0;
        k   = 0;
        while (pos < 256) begin
            idx = 8'(8'h40 + pos);
            if (PATTERN[k] && pos < 255) begin
                image[idx]         = {idx, 8'h13};
                image[8'(idx + 1)] = {~idx, 8'h5A};
                pos = pos + 2;
            end else begin
                image[idx] = {idx, 8'h41};
                pos = pos + 1;
            end
            k = (k + 1) % 16;
        end
    endtask

    task automatic wait_instr_count(input int unsigned target);
        int unsigned cycles;
        cycles = 0;
        while (mon_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            cycles = cycles + 1;
        end
        if (mon_count < target) begin
            $display("Timeout while waiting for instructions, saw %0d of %0d", mon_count, target);
            timeouts = timeouts + 1;
        end
    endtask

    // ======================================================================
    // Memory model and per-cycle random inputs
    // ======================================================================

    // Responses leave in request order, 1 to 4 cycles after acceptance
    always @(posedge clk_i) begin
        logic             mode_now;
        int unsigned      due;
        fetch_pkg::addr_t rsp_addr;
        mode_now = rand_mode;
        cycle    = cycle + 1;
        if (req_valid && req_ready) begin
            lcg_state = lcg_next(lcg_state);
            due = cycle + 1 + int'(lcg_state[31:30]);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            pend_addr.push_back(req.addr);
            pend_due.push_back(due);
        end
        #1;
        if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
            rsp_addr      = pend_addr.pop_front();
            due           = pend_due.pop_front();
            rsp_valid     = 1'b1;
            rsp_word.full = {image[{rsp_addr[8:2], 1'b1}], image[{rsp_addr[8:2], 1'b0}]};
        end else begin
            rsp_valid = 1'b0;
        end
        lcg_state   = lcg_next(lcg_state);
        req_ready   = !mode_now || lcg_state[31];
        instr_ready = !mode_now || lcg_state[30];
    end

    // ======================================================================
    // Stimulus table and report
    // ======================================================================

    initial begin
        stim_row_t   row;
        int unsigned base;
        int          r;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        req_ready   = 1'b0;
        rsp_valid   = 1'b0;
        rsp_word    = '0;
        instr_ready = 1'b0;
        rand_mode   = 1'b0;
        mon_load    = 1'b1;
        mon_start   = RESET_PC;
        timeouts    = 0;
        lcg_state   = 32'd84;
        cycle       = 0;
        last_due    = 0;
        build_image();
        // Reset start, then redirects to odd-halfword, crossing and wrapping targets
        stim_table[0] = {1'b0, 1'b0, RESET_PC, 8'd12};
        stim_table[1] = {1'b1, 1'b0, 32'h0000_010A, 8'd10};
        stim_table[2] = {1'b1, 1'b1, 32'h0000_0096, 8'd40};
        stim_table[3] = {1'b1, 1'b1, 32'h0000_0082, 8'd60};
        stim_table[4] = {1'b1, 1'b0, 32'h0000_01F2, 8'd20};
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i  = 1'b1;
        mon_load = 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            row = stim_table[r];
            if (row.redirect) begin
                redirect    = 1'b1;
                redirect_pc = row.target;
                mon_load    = 1'b1;
                mon_start   = row.target;
            end
            rand_mode = row.rand_ready;
            base      = mon_count;
            @(posedge clk_i);
            #1;
            redirect = 1'b0;
            mon_load = 1'b0;
            wait_instr_count(base + row.count);
        end
        repeat (4) @(posedge clk_i);
        sva_errors = fetch_front_i.fetch_front_chk_i.fail_count;
        $display("Errors: %0d compare, %0d assertion, %0d timeout",
                 mon_errors, sva_errors, timeouts);
        if (mon_errors == 0 && sva_errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/fetch_buffer.sv
hw/align_ctrl.sv
hw/instr_assembler.sv
hw/fetch_front.sv
tests/fetch_front_chk.sv
tests/fetch_front_mon.sv
tests/fetch_front_tb.sv

// File: Bender.yml
package:
  name: fetch_front

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/pc_gen.sv
      - hw/fetch_buffer.sv
      - hw/align_ctrl.sv
      - hw/instr_assembler.sv
      - hw/fetch_front.sv
  - target: test
    files:
      - tests/fetch_front_chk.sv
      - tests/fetch_front_mon.sv
      - tests/fetch_front_tb.sv
